/* dv/back_end_tests.txt */
// stall_n take_new_pc new_pc alu_out rd_data_2 sext_imm lbi slbi ofl zero ltz lteq
// set_sel wb_sel wr_reg reg_wr_en mem_en mem_wr_en, all hex, one cycle per line
1 0 0000 1234 0000 0000 0000 0000 0 0 0 0 0 0 1 1 0 0
1 0 0000 0000 0000 0000 00a5 0000 0 0 0 0 0 2 2 1 0 0
1 0 0000 0000 0000 0000 0000 5aa5 0 0 0 0 0 3 3 1 0 0
1 0 0000 0000 0000 fff0 0000 0000 0 0 0 0 0 5 4 1 0 0
1 0 0000 0000 0000 0000 0000 0000 0 1 0 0 0 4 5 1 0 0
1 0 0000 0000 0000 0000 0000 0000 1 1 0 1 1 4 6 1 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 1 1 1 4 7 1 0 0
1 0 0000 0000 0000 0000 0000 0000 1 1 1 0 2 4 0 1 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 0 1 2 4 1 1 0 0
1 0 0000 0000 0000 0000 0000 0000 1 0 0 0 3 4 2 1 0 0
1 0 0000 0000 0000 0000 0000 0000 0 1 1 1 3 4 3 1 0 0
1 0 0000 0026 1357 0000 0000 0000 0 0 0 0 0 0 0 0 1 1
1 0 0000 0020 beef 0000 0000 0000 0 0 0 0 0 0 0 0 1 1
1 0 0000 0020 0000 0000 0000 0000 0 0 0 0 0 1 4 1 1 0
1 0 0000 0022 cafe 0000 0000 0000 0 0 0 0 0 0 0 0 1 1
1 0 0000 0022 0000 0000 0000 0000 0 0 0 0 0 1 5 1 1 0
1 0 0000 4321 0000 0000 0000 0000 0 0 0 0 0 0 6 1 0 0
0 0 0000 0020 1111 0000 0000 0000 0 0 0 0 0 0 0 0 1 1
0 0 0000 7777 0000 0000 0000 0000 0 0 0 0 0 0 7 1 0 0
1 0 0000 0020 0000 0000 0000 0000 0 0 0 0 0 1 7 1 1 0
1 1 0020 0024 0f0f 0000 0000 0000 0 0 0 0 0 0 0 0 1 1
1 0 0000 0024 0000 0000 0000 0000 0 0 0 0 0 1 1 1 1 0
1 1 0024 5555 0000 0000 0000 0000 0 0 0 0 0 0 2 1 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
0 1 0020 0026 0000 0000 0000 0000 0 0 0 0 0 1 3 1 1 0
1 0 0000 0026 0000 0000 0000 0000 0 0 0 0 0 1 3 1 1 0
1 0 0000 0028 2468 0000 0000 0000 0 0 0 0 0 0 0 0 1 1
1 0 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
1 0 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
1 0 0000 1000 0000 0000 0000 0000 0 0 0 0 0 0 2 1 0 0

/* sources.f */
common/core_pkg.sv
common/mem_port_if.sv
source/ex_mem_latch.sv
source/mem_wb_latch.sv
memory/mem_arbiter.sv
memory/unified_ram.sv
fetch/fetch_unit.sv
source/back_end_top.sv
dv/back_end_tb.sv

/* Makefile */
TOP := back_end_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* dv/back_end_tb.sv */
module back_end_tb
   import core_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int addr_w = 8;
   localparam int n_fields = 18;   // columns per line of the vector file
   localparam int max_vec = 64;
   localparam int wait_limit = 50;
   localparam logic [15:0] final_pc = 16'h0020;

   // one expected writeback slot, bubbles included
   typedef struct packed {
      logic                 wr;
      logic [reg_sel_w-1:0] rg;
      logic                 from_mem;
      logic [data_w-1:0]    data;
      logic                 store;
      logic [addr_w-1:0]    addr;
      logic [data_w-1:0]    sdata;
   } wb_exp_t;

   logic clk, rst_n, stall_n, take_new_pc;
   logic [data_w-1:0] new_pc, in_alu_out, in_rd_data_2, in_sext_imm, in_lbi, in_slbi;
   logic in_alu_ofl, in_alu_zero, in_alu_ltz, in_alu_lteq;
   logic [1:0] in_set_sel;
   logic [2:0] in_wb_sel;
   logic [reg_sel_w-1:0] in_wr_reg;
   logic in_reg_wr_en, in_mem_en, in_mem_wr_en;
   logic wb_en, instr_valid;
   logic [reg_sel_w-1:0] wb_reg;
   logic [data_w-1:0] wb_data, instr, instr_pc;

   logic [15:0] vec_mem [n_fields*max_vec];
   logic [15:0] cur [n_fields];
   logic [data_w-1:0] shadow [2**addr_w];  // what the ram should hold
   wb_exp_t exp_q[$];
   logic [data_w-1:0] exp_pc;
   logic redirect_pending;
   int errors, checks, n_instr;

   always #4 clk = ~clk;

   back_end_top #(.addr_w(addr_w)) dut0 (
      .clk, .rst_n, .stall_n, .take_new_pc, .new_pc,
      .in_alu_out, .in_rd_data_2, .in_sext_imm, .in_lbi, .in_slbi,
      .in_alu_ofl, .in_alu_zero, .in_alu_ltz, .in_alu_lteq,
      .in_set_sel, .in_wb_sel, .in_wr_reg, .in_reg_wr_en, .in_mem_en, .in_mem_wr_en,
      .wb_en, .wb_reg, .wb_data, .instr, .instr_pc, .instr_valid
   );

   task automatic set_idle();
      for (int k = 0; k < n_fields; k++) begin
         cur[k] = '0;
      end
      cur[0] = 16'd1;  // stall_n high, nothing enabled
   endtask

   task automatic load_vector(input int v);
      for (int k = 0; k < n_fields; k++) begin
         cur[k] = vec_mem[v*n_fields + k];
      end
   endtask

   // drive cur onto the dut and queue what writeback must show 2 edges later
   task automatic apply_cur();
      wb_exp_t e;
      logic    eff;
      logic    set_bit;
      stall_n      = cur[0][0];
      take_new_pc  = cur[1][0];
      new_pc       = cur[2];
      in_alu_out   = cur[3];
      in_rd_data_2 = cur[4];
      in_sext_imm  = cur[5];
      in_lbi       = cur[6];
      in_slbi      = cur[7];
      in_alu_ofl   = cur[8][0];
      in_alu_zero  = cur[9][0];
      in_alu_ltz   = cur[10][0];
      in_alu_lteq  = cur[11][0];
      in_set_sel   = cur[12][1:0];
      in_wb_sel    = cur[13][2:0];
      in_wr_reg    = cur[14][reg_sel_w-1:0];
      in_reg_wr_en = cur[15][0];
      in_mem_en    = cur[16][0];
      in_mem_wr_en = cur[17][0];
      eff = cur[0][0] & ~cur[1][0];  // redirect or stall makes a bubble
      case (set_sel_t'(cur[12][1:0]))
         SET_EQ:  set_bit = cur[9][0];
         SET_LT:  set_bit = cur[10][0];
         SET_LE:  set_bit = cur[11][0];
         default: set_bit = cur[8][0];
      endcase
      e.wr       = eff & cur[15][0];
      e.rg       = cur[14][reg_sel_w-1:0];
      e.from_mem = (wb_sel_t'(cur[13][2:0]) == WB_MEM);
      case (wb_sel_t'(cur[13][2:0]))
         WB_LBI:  e.data = cur[6];
         WB_SLBI: e.data = cur[7];
         WB_SET:  e.data = {15'd0, set_bit};
         WB_IMM:  e.data = cur[5];
         default: e.data = cur[3];
      endcase
      e.store = eff & cur[16][0] & cur[17][0];
      e.addr  = cur[3][addr_w:1];
      e.sdata = cur[4];
      exp_q.push_back(e);
      if (cur[1][0]) begin
         exp_pc           = cur[2];
         redirect_pending = 1'b1;
      end
   endtask

   // outputs after the last edge, then the stores of that edge
   task automatic check_cycle();
      wb_exp_t           e;
      logic [data_w-1:0] want;
      e = exp_q.pop_front();
      checks++;
      assert (wb_en == e.wr) else begin
         errors++;
         $display("FAIL wb_en: got 0x%h expected 0x%h", wb_en, e.wr);
      end
      if (e.wr) begin
         want = e.from_mem ? shadow[e.addr] : e.data;
         checks += 2;
         assert (wb_reg == e.rg) else begin
            errors++;
            $display("FAIL wb_reg: got 0x%h expected 0x%h", wb_reg, e.rg);
         end
         assert (wb_data == want) else begin
            errors++;
            $display("FAIL wb_data: got 0x%h expected 0x%h", wb_data, want);
         end
      end
      if (instr_valid) begin
         checks += 2;
         assert (instr_pc == exp_pc) else begin
            errors++;
            $display("FAIL instr_pc: got 0x%h expected 0x%h", instr_pc, exp_pc);
         end
         assert (instr == shadow[exp_pc[addr_w:1]]) else begin
            errors++;
            $display("FAIL instr: got 0x%h expected 0x%h", instr, shadow[exp_pc[addr_w:1]]);
         end
         exp_pc           = exp_pc + 16'd2;
         redirect_pending = 1'b0;
         n_instr++;
      end
      if (e.store) begin
         shadow[e.addr] = e.sdata;
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   initial begin
      int n_vec;
      int cnt;
      clk = 1'b0;
      rst_n = 1'b0;
      errors = 0;
      checks = 0;
      n_instr = 0;
      exp_pc = '0;
      redirect_pending = 1'b0;
      for (int i = 0; i < n_fields*max_vec; i++) begin
         vec_mem[i] = {4'hf, 12'(i)};  // never a legal stall_n, marks the end
      end
      for (int i = 0; i < 2**addr_w; i++) begin
         shadow[i] = '0;
      end
      $readmemh("dv/back_end_tests.txt", vec_mem);
      n_vec = 0;
      while (n_vec < max_vec && vec_mem[n_vec*n_fields] <= 16'd1) begin
         n_vec++;
      end
      if (n_vec == 0) begin
         errors++;
         $display("no vectors could be read from dv/back_end_tests.txt");
      end
      set_idle();
      apply_cur();  // the two slots in flight out of reset are empty
      apply_cur();
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      for (int v = 0; v < n_vec; v++) begin
         check_cycle();
         load_vector(v);
         apply_cur();
         step();
      end
      set_idle();
      repeat (2) begin
         check_cycle();
         apply_cur();
         step();
      end
      // one last redirect, then wait for its first instruction
      check_cycle();
      cur[1] = 16'd1;
      cur[2] = final_pc;
      apply_cur();
      step();
      set_idle();
      cnt = 0;
      while (redirect_pending && cnt < wait_limit) begin
         check_cycle();
         apply_cur();
         step();
         cnt++;
      end
      if (redirect_pending) begin
         errors++;
         $display("timeout: no instruction came back within %0d cycles of the redirect",
                  wait_limit);
      end
      $display("checks %0d, errors %0d, instructions %0d", checks, errors, n_instr);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* source/back_end_top.sv */
module back_end_top
   import core_pkg::*;
#(
   parameter int addr_w = 8
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 stall_n,
   input  logic                 take_new_pc,
   input  logic [data_w-1:0]    new_pc,
   input  logic [data_w-1:0]    in_alu_out,
   input  logic [data_w-1:0]    in_rd_data_2,
   input  logic [data_w-1:0]    in_sext_imm,
   input  logic [data_w-1:0]    in_lbi,
   input  logic [data_w-1:0]    in_slbi,
   input  logic                 in_alu_ofl,
   input  logic                 in_alu_zero,
   input  logic                 in_alu_ltz,
   input  logic                 in_alu_lteq,
   input  logic [1:0]           in_set_sel,
   input  logic [2:0]           in_wb_sel,
   input  logic [reg_sel_w-1:0] in_wr_reg,
   input  logic                 in_reg_wr_en,
   input  logic                 in_mem_en,
   input  logic                 in_mem_wr_en,
   output logic                 wb_en,
   output logic [reg_sel_w-1:0] wb_reg,
   output logic [data_w-1:0]    wb_data,
   output logic [data_w-1:0]    instr,
   output logic [data_w-1:0]    instr_pc,
   output logic                 instr_valid
);

   ex_mem_t ex;
   ex_mem_t ex_mem_q;

   always_comb begin
      ex.alu_out   = in_alu_out;
      ex.rd_data_2 = in_rd_data_2;
      ex.sext_imm  = in_sext_imm;
      ex.lbi       = in_lbi;
      ex.slbi      = in_slbi;
      ex.alu_ofl   = in_alu_ofl;
      ex.alu_zero  = in_alu_zero;
      ex.alu_ltz   = in_alu_ltz;
      ex.alu_lteq  = in_alu_lteq;
      ex.set_sel   = set_sel_t'(in_set_sel);
      ex.wb_sel    = wb_sel_t'(in_wb_sel);
      ex.wr_reg    = in_wr_reg;
      ex.reg_wr_en = in_reg_wr_en;
      ex.mem_en    = in_mem_en;
      ex.mem_wr_en = in_mem_wr_en;
   end

   mem_port_if #(.addr_w(addr_w)) data_port ();
   mem_port_if #(.addr_w(addr_w)) fetch_port ();
   mem_port_if #(.addr_w(addr_w)) ram_port ();

   ex_mem_latch #(.addr_w(addr_w)) ex_mem0 (
      .clk, .rst_n, .stall_n, .take_new_pc,
      .ex, .q(ex_mem_q), .mem(data_port.requester)
   );

   mem_wb_latch mem_wb0 (
      .clk, .rst_n, .q(ex_mem_q), .mem_rdata(data_port.rdata),
      .wb_en, .wb_reg, .wb_data
   );

   fetch_unit #(.addr_w(addr_w)) fetch0 (
      .clk, .rst_n, .take_new_pc, .new_pc, .mem(fetch_port.requester),
      .instr, .instr_pc, .instr_valid
   );

   mem_arbiter #(.addr_w(addr_w)) arb0 (
      .clk, .rst_n, .data(data_port.arbiter), .fetch(fetch_port.arbiter),
      .ram(ram_port.requester)
   );

   unified_ram #(.addr_w(addr_w)) ram0 (.clk, .ram(ram_port.arbiter));

endmodule

/* fetch/fetch_unit.sv */
module fetch_unit
   import core_pkg::*;
#(
   parameter int addr_w = 8
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              take_new_pc,
   input  logic [data_w-1:0] new_pc,
   mem_port_if.requester     mem,
   output logic [data_w-1:0] instr,
   output logic [data_w-1:0] instr_pc,
   output logic              instr_valid
);

   logic [data_w-1:0] pc;
   logic [data_w-1:0] pend_pc;  // pc of the read now in the ram
   logic              pend;

   assign mem.req   = 1'b1;  // always hungry, the data side takes priority
   assign mem.we    = 1'b0;
   assign mem.addr  = pc[addr_w:1];
   assign mem.wdata = '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc          <= '0;
         pend        <= 1'b0;
         instr_valid <= 1'b0;
      end else begin
         if (take_new_pc) begin
            pc <= new_pc;
         end else if (mem.gnt) begin
            pc <= pc + data_w'(2);
         end
         // a redirect kills both the read just issued and the one returning
         pend        <= mem.gnt & ~take_new_pc;
         instr_valid <= pend & ~take_new_pc;
      end
   end

   always_ff @(posedge clk) begin
      if (mem.gnt) begin
         pend_pc <= pc;
      end
      if (pend) begin
         instr    <= mem.rdata;
         instr_pc <= pend_pc;
      end
   end

endmodule

/* memory/unified_ram.sv */
module unified_ram
   import core_pkg::*;
#(
   parameter int addr_w = 8
) (
   input  logic        clk,
   mem_port_if.arbiter ram
);

   localparam int depth = 2 ** addr_w;

   logic [data_w-1:0] mem [depth] = '{default: '0};
   logic [data_w-1:0] rdata_q;

   // single port, never busy
   assign ram.gnt = ram.req;

   always_ff @(posedge clk) begin
      if (ram.req) begin
         if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
         end else begin
            rdata_q <= mem[ram.addr];
         end
      end
   end

   assign ram.rdata = rdata_q;  // holds until the next read

endmodule

/* memory/mem_arbiter.sv */
module mem_arbiter #(
   parameter int addr_w = 8
) (
   input  logic          clk,
   input  logic          rst_n,
   mem_port_if.arbiter   data,
   mem_port_if.arbiter   fetch,
   mem_port_if.requester ram
);

   logic              data_sel;
   logic [addr_w-1:0] addr_mux;
   logic              owner_data;  // who gets the read data in flight

   // data always wins, fetch fills the idle cycles
   assign data_sel = data.req;

   assign ram.req   = data.req | fetch.req;
   assign ram.we    = data_sel ? data.we : fetch.we;
   assign addr_mux  = data_sel ? data.addr : fetch.addr;
   assign ram.addr  = addr_mux;
   assign ram.wdata = data_sel ? data.wdata : fetch.wdata;

   assign data.gnt  = data.req & ram.gnt;
   assign fetch.gnt = fetch.req & ~data_sel & ram.gnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_data <= 1'b1;
      end else if (ram.gnt && !ram.we) begin
         owner_data <= data_sel;
      end
   end

   assign data.rdata  = owner_data ? ram.rdata : '0;
   assign fetch.rdata = owner_data ? '0 : ram.rdata;

   // the data side never waits, so the ram must take it at once
   a_data_no_wait: assert property (
      @(posedge clk) disable iff (!rst_n)
      data.req |-> data.gnt
   );

   // instruction side is read only
   a_fetch_no_write: assert property (
      @(posedge clk) disable iff (!rst_n)
      fetch.gnt |-> !ram.we
   );

endmodule

/* source/mem_wb_latch.sv */
module mem_wb_latch
   import core_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  ex_mem_t              q,
   input  logic [data_w-1:0]    mem_rdata,  // valid in the cycle after the access
   output logic                 wb_en,
   output logic [reg_sel_w-1:0] wb_reg,
   output logic [data_w-1:0]    wb_data
);

   logic              set_val;
   logic              set_q;
   wb_sel_t           wb_sel_q;
   logic [data_w-1:0] alu_out_q;
   logic [data_w-1:0] lbi_q;
   logic [data_w-1:0] slbi_q;
   logic [data_w-1:0] imm_q;

   always_comb begin
      unique case (q.set_sel)
         SET_EQ:  set_val = q.alu_zero;
         SET_LT:  set_val = q.alu_ltz;
         SET_LE:  set_val = q.alu_lteq;
         default: set_val = q.alu_ofl;  // SET_CO
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_en <= 1'b0;
      end else begin
         wb_en <= q.reg_wr_en;
      end
   end

   always_ff @(posedge clk) begin
      wb_reg    <= q.wr_reg;
      wb_sel_q  <= q.wb_sel;
      set_q     <= set_val;
      alu_out_q <= q.alu_out;
      lbi_q     <= q.lbi;
      slbi_q    <= q.slbi;
      imm_q     <= q.sext_imm;
   end

   always_comb begin
      unique case (wb_sel_q)
         WB_MEM:  wb_data = mem_rdata;  // ram read already happened on this edge
         WB_LBI:  wb_data = lbi_q;
         WB_SLBI: wb_data = slbi_q;
         WB_SET:  wb_data = {{(data_w - 1){1'b0}}, set_q};
         WB_IMM:  wb_data = imm_q;
         default: wb_data = alu_out_q;
      endcase
   end

   // load data is only meaningful if the slot really read the ram
   a_mem_wb_is_load: assert property (
      @(posedge clk) disable iff (!rst_n)
      (wb_en && wb_sel_q == WB_MEM) |-> $past(q.mem_en && !q.mem_wr_en)
   );

endmodule

/* source/ex_mem_latch.sv */
module ex_mem_latch
   import core_pkg::*;
#(
   parameter int addr_w = 8
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          stall_n,      // low when the upstream stage stalls
   input  logic          take_new_pc,  // redirect, squashes this slot
   input  ex_mem_t       ex,
   output ex_mem_t       q,
   mem_port_if.requester mem
);

   logic    load;
   ex_mem_t data_q;
   logic    reg_wr_en_q;
   logic    mem_en_q;
   logic    mem_wr_en_q;

   // redirect wins over the upstream stall
   assign load = take_new_pc ? 1'b0 : stall_n;

   // payload holds its last value through a bubble
   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= ex;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_wr_en_q <= 1'b0;
         mem_en_q    <= 1'b0;
         mem_wr_en_q <= 1'b0;
      end else begin
         reg_wr_en_q <= load & ex.reg_wr_en;
         mem_en_q    <= load & ex.mem_en;
         mem_wr_en_q <= load & ex.mem_wr_en;
      end
   end

   always_comb begin
      q           = data_q;
      q.reg_wr_en = reg_wr_en_q;
      q.mem_en    = mem_en_q;
      q.mem_wr_en = mem_wr_en_q;
   end

   // data side of the shared ram
   assign mem.req   = q.mem_en;
   assign mem.we    = q.mem_wr_en;
   assign mem.addr  = q.alu_out[addr_w:1];  // byte address to word address
   assign mem.wdata = q.rd_data_2;

   // a store only leaves this stage as a real access, and the arbiter
   // never makes the data side wait
   a_store_granted: assert property (
      @(posedge clk) disable iff (!rst_n)
      q.mem_wr_en |-> (q.mem_en && mem.gnt)
   );

endmodule

/* common/mem_port_if.sv */
interface mem_port_if
   import core_pkg::*;
#(
   parameter int addr_w = 8
) ();

   logic              req;    // level, held for as long as the access is wanted
   logic              we;
   logic [addr_w-1:0] addr;   // word address
   logic [data_w-1:0] wdata;
   logic [data_w-1:0] rdata;  // one cycle after a granted read
   logic              gnt;    // same cycle as req

   modport requester (
      output req, we, addr, wdata,
      input  rdata, gnt
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output rdata, gnt
   );

endinterface

/* common/core_pkg.sv */
package core_pkg;

   localparam int data_w    = 16;
   localparam int reg_sel_w = 3;

   // writeback source select
   typedef enum logic [2:0] {
      WB_ALU  = 3'd0,
      WB_MEM  = 3'd1,
      WB_LBI  = 3'd2,
      WB_SLBI = 3'd3,
      WB_SET  = 3'd4,
      WB_IMM  = 3'd5
   } wb_sel_t;

   // set instruction condition, picks one alu flag
   typedef enum logic [1:0] {
      SET_EQ = 2'd0,  // zero
      SET_LT = 2'd1,  // ltz
      SET_LE = 2'd2,  // lteq
      SET_CO = 2'd3   // overflow
   } set_sel_t;

   // everything the execute stage hands to memory and writeback
   typedef struct packed {
      logic [data_w-1:0]    alu_out;    // also the byte address of a load or store
      logic [data_w-1:0]    rd_data_2;  // store data
      logic [data_w-1:0]    sext_imm;
      logic [data_w-1:0]    lbi;
      logic [data_w-1:0]    slbi;
      logic                 alu_ofl;
      logic                 alu_zero;
      logic                 alu_ltz;
      logic                 alu_lteq;
      set_sel_t             set_sel;
      wb_sel_t              wb_sel;
      logic [reg_sel_w-1:0] wr_reg;
      logic                 reg_wr_en;
      logic                 mem_en;
      logic                 mem_wr_en;
   } ex_mem_t;

endpackage
